/* rtl/nabp_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_line_buffer
    import nabp_pkg::*;
#(
    parameter int DATA_WIDTH     = 16,
    parameter int NUM_PARTITIONS = 4,
    parameter int PARTITION_SIZE = 8
) (
    input  wire logic                  clk,
    input  wire lb_ctrl_t              lb_ctrl,
    input  wire logic [DATA_WIDTH-1:0] shift_in,
    output logic [(NUM_PARTITIONS-1)*DATA_WIDTH-1:0] taps
);

    localparam int DEPTH = (NUM_PARTITIONS - 1) * PARTITION_SIZE;

    // word 0 holds the most recent sample
    logic [DATA_WIDTH-1:0] line [DEPTH];

    always_ff @(posedge clk) begin
        if (lb_ctrl.clear) begin
            for (int i = 0; i < DEPTH; i++) begin
                line[i] <= '0;
            end
        end else if (lb_ctrl.shift_en) begin
            line[0] <= shift_in;
            for (int i = 1; i < DEPTH; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    // one tap at the end of every partition
    for (genvar k = 0; k < NUM_PARTITIONS - 1; k++) begin : g_tap
        assign taps[k*DATA_WIDTH +: DATA_WIDTH] = line[PARTITION_SIZE*(k+1)-1];
    end

endmodule

`default_nettype wire

/* rtl/nabp_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_mapper
    import nabp_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [ACCU_WIDTH-1:0] map_accu_init,
    input  wire logic [ACCU_WIDTH-1:0] map_accu_base,
    input  wire map_ctrl_t             map_ctrl,
    output logic [S_WIDTH-1:0]         fr_s_val
);

    logic [ACCU_WIDTH-1:0] accu;
    logic [ACCU_WIDTH-1:0] accu_next;

    // load on kick, step on shift, otherwise hold
    always_comb begin
        accu_next = accu;
        if (map_ctrl.kick) begin
            accu_next = map_accu_init;
        end else if (map_ctrl.shift_en && !map_ctrl.done) begin
            // wraps at ACCU_WIDTH
            accu_next = accu + map_accu_base;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            accu     <= '0;
            fr_s_val <= '0;
        end else begin
            accu     <= accu_next;
            // integer part only goes to the RAM
            fr_s_val <= accu_next[ACCU_WIDTH-1:ACCU_FRAC];
        end
    end

endmodule

`default_nettype wire

/* rtl/nabp_pkg.sv */
`default_nettype none

package nabp_pkg;

    // fixed-point layout shared by every accumulator
    localparam int ACCU_FRAC  = 8;
    localparam int S_WIDTH    = 10;
    localparam int ACCU_WIDTH = ACCU_FRAC + S_WIDTH;

    // settings for one iteration, from the swap controller
    typedef struct packed {
        // only bits ACCU_FRAC downto 0 are used
        logic [ACCU_WIDTH-1:0] shift_accu_base;
        logic [ACCU_WIDTH-1:0] map_accu_init;
        logic [ACCU_WIDTH-1:0] map_accu_base;
    } swap_params_t;

    // shifter to mapper
    typedef struct packed {
        logic kick;
        logic shift_en;
        logic done;
    } map_ctrl_t;

    // shifter to line buffer
    typedef struct packed {
        logic clear;
        logic shift_en;
    } lb_ctrl_t;

    // iteration sequencing
    typedef enum logic [2:0] {
        sc_idle,
        sc_fill,
        sc_swap,
        sc_shift,
        sc_next
    } sc_state_t;

endpackage

`default_nettype wire

/* rtl/nabp_processing_swappable.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_processing_swappable
    import nabp_pkg::*;
#(
    parameter int DATA_WIDTH     = 16,
    parameter int NUM_PARTITIONS = 4,
    parameter int PARTITION_SIZE = 8
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // swap controller
    input  wire swap_params_t          sw_params,
    input  wire logic                  sw_swap_ack,
    input  wire logic                  sw_next_itr_ack,
    // filtered RAM read data
    input  wire logic [DATA_WIDTH-1:0] fr_val,
    output logic                       sw_swap,
    output logic                       sw_next_itr,
    output logic                       sw_pe_en,
    // filtered RAM address
    output logic [S_WIDTH-1:0]         fr_s_val,
    // to PEs, tap 0 in the lowest slot
    output logic [NUM_PARTITIONS*DATA_WIDTH-1:0] pe_taps
);

    logic                  fill_kick;
    logic                  shift_kick;
    logic                  fill_done;
    logic                  shift_done;
    logic [ACCU_WIDTH-1:0] shift_accu_base;
    logic [ACCU_WIDTH-1:0] map_accu_init;
    logic [ACCU_WIDTH-1:0] map_accu_base;
    map_ctrl_t             map_ctrl;
    lb_ctrl_t              lb_ctrl;
    lb_ctrl_t              lb_ctrl_rst;
    logic [DATA_WIDTH-1:0] tap0;
    logic [(NUM_PARTITIONS-1)*DATA_WIDTH-1:0] lb_taps;

    nabp_state_control state_control (
        .clk             (clk),
        .reset           (reset),
        .sw_params       (sw_params),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr_ack (sw_next_itr_ack),
        .fill_done       (fill_done),
        .shift_done      (shift_done),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .fill_kick       (fill_kick),
        .shift_kick      (shift_kick),
        .shift_accu_base (shift_accu_base),
        .map_accu_init   (map_accu_init),
        .map_accu_base   (map_accu_base)
    );

    nabp_shifter #(
        .NUM_PARTITIONS (NUM_PARTITIONS),
        .PARTITION_SIZE (PARTITION_SIZE)
    ) shifter (
        .clk             (clk),
        .reset           (reset),
        .fill_kick       (fill_kick),
        .shift_kick      (shift_kick),
        .shift_accu_base (shift_accu_base),
        .fill_done       (fill_done),
        .shift_done      (shift_done),
        .map_ctrl        (map_ctrl),
        .lb_ctrl         (lb_ctrl),
        .sw_pe_en        (sw_pe_en)
    );

    nabp_mapper mapper (
        .clk           (clk),
        .reset         (reset),
        .map_accu_init (map_accu_init),
        .map_accu_base (map_accu_base),
        .map_ctrl      (map_ctrl),
        .fr_s_val      (fr_s_val)
    );

    // RAM data one cycle after the address, registered here as tap 0
    always_ff @(posedge clk) begin
        tap0 <= fr_val;
    end

    // line buffer also empties while reset is held
    assign lb_ctrl_rst = '{clear: lb_ctrl.clear | reset, shift_en: lb_ctrl.shift_en};

    nabp_line_buffer #(
        .DATA_WIDTH     (DATA_WIDTH),
        .NUM_PARTITIONS (NUM_PARTITIONS),
        .PARTITION_SIZE (PARTITION_SIZE)
    ) line_buffer (
        .clk      (clk),
        .lb_ctrl  (lb_ctrl_rst),
        .shift_in (tap0),
        .taps     (lb_taps)
    );

    assign pe_taps = {lb_taps, tap0};

endmodule

`default_nettype wire

/* rtl/nabp_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_shifter
    import nabp_pkg::*;
#(
    parameter int NUM_PARTITIONS = 4,
    parameter int PARTITION_SIZE = 8
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  fill_kick,
    input  wire logic                  shift_kick,
    input  wire logic [ACCU_WIDTH-1:0] shift_accu_base,
    output logic                       fill_done,
    output logic                       shift_done,
    output map_ctrl_t                  map_ctrl,
    output lb_ctrl_t                   lb_ctrl,
    output logic                       sw_pe_en
);

    localparam int FILL_LEN  = NUM_PARTITIONS * PARTITION_SIZE;
    localparam int CNT_WIDTH = $clog2(FILL_LEN + 1);

    typedef enum logic [1:0] {
        sh_idle,
        sh_fill,
        sh_shift,
        sh_drain
    } sh_state_t;

    sh_state_t            state;
    logic [CNT_WIDTH-1:0] cnt;
    logic [ACCU_FRAC-1:0] phase;
    logic [ACCU_FRAC:0]   phase_sum;
    logic                 fill_pass;
    logic                 kick_q;
    logic                 clear_q;
    logic                 map_shift_q;
    logic                 done_q;
    // covers RAM latency plus the tap 0 register
    logic [1:0]           dly;

    // step of at most one whole sample per cycle, bit ACCU_FRAC is the carry
    assign phase_sum = {1'b0, phase} + shift_accu_base[ACCU_FRAC:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= sh_idle;
            cnt         <= '0;
            phase       <= '0;
            fill_pass   <= 1'b0;
            kick_q      <= 1'b0;
            clear_q     <= 1'b0;
            map_shift_q <= 1'b0;
            done_q      <= 1'b0;
            fill_done   <= 1'b0;
            shift_done  <= 1'b0;
            sw_pe_en    <= 1'b0;
            dly         <= '0;
        end else begin
            kick_q     <= 1'b0;
            clear_q    <= 1'b0;
            done_q     <= 1'b0;
            fill_done  <= 1'b0;
            shift_done <= 1'b0;
            dly        <= {dly[0], map_shift_q};
            case (state)
                sh_idle: begin
                    if (fill_kick) begin
                        kick_q    <= 1'b1;
                        clear_q   <= 1'b1;
                        cnt       <= '0;
                        fill_pass <= 1'b1;
                        state     <= sh_fill;
                    end else if (shift_kick) begin
                        // first PE cycle, phase starts from zero
                        sw_pe_en    <= 1'b1;
                        map_shift_q <= phase_sum[ACCU_FRAC];
                        phase       <= phase_sum[ACCU_FRAC-1:0];
                        cnt         <= CNT_WIDTH'(1);
                        fill_pass   <= 1'b0;
                        state       <= sh_shift;
                    end
                end
                sh_fill: begin
                    if (cnt == CNT_WIDTH'(FILL_LEN)) begin
                        map_shift_q <= 1'b0;
                        state       <= sh_drain;
                    end else begin
                        map_shift_q <= 1'b1;
                        cnt         <= cnt + 1'b1;
                    end
                end
                sh_shift: begin
                    if (cnt == CNT_WIDTH'(PARTITION_SIZE)) begin
                        sw_pe_en    <= 1'b0;
                        map_shift_q <= 1'b0;
                        state       <= sh_drain;
                    end else begin
                        map_shift_q <= phase_sum[ACCU_FRAC];
                        phase       <= phase_sum[ACCU_FRAC-1:0];
                        cnt         <= cnt + 1'b1;
                    end
                end
                sh_drain: begin
                    // last line buffer shift happens this cycle at the latest
                    if (!dly[0]) begin
                        done_q     <= 1'b1;
                        fill_done  <= fill_pass;
                        shift_done <= !fill_pass;
                        phase      <= '0;
                        state      <= sh_idle;
                    end
                end
                default: begin
                    state <= sh_idle;
                end
            endcase
        end
    end

    assign map_ctrl = '{kick: kick_q, shift_en: map_shift_q, done: done_q};
    assign lb_ctrl  = '{clear: clear_q, shift_en: dly[1]};

endmodule

`default_nettype wire

/* rtl/nabp_state_control.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_state_control
    import nabp_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    // swap controller side
    input  wire swap_params_t          sw_params,
    input  wire logic                  sw_swap_ack,
    input  wire logic                  sw_next_itr_ack,
    // from shifter
    input  wire logic                  fill_done,
    input  wire logic                  shift_done,
    // requests to swap controller
    output logic                       sw_swap,
    output logic                       sw_next_itr,
    // to shifter
    output logic                       fill_kick,
    output logic                       shift_kick,
    output logic [ACCU_WIDTH-1:0]      shift_accu_base,
    // to mapper
    output logic [ACCU_WIDTH-1:0]      map_accu_init,
    output logic [ACCU_WIDTH-1:0]      map_accu_base
);

    sc_state_t    state;
    swap_params_t params_q;
    logic         start_itr;

    // new iteration: first cycle out of reset, or next-iteration acknowledged
    assign start_itr = (state == sc_idle) || (state == sc_next && sw_next_itr_ack);

    // settings held for the whole iteration
    always_ff @(posedge clk) begin
        if (start_itr) begin
            params_q <= sw_params;
        end
    end

    assign shift_accu_base = params_q.shift_accu_base;
    assign map_accu_init   = params_q.map_accu_init;
    assign map_accu_base   = params_q.map_accu_base;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= sc_idle;
            sw_swap     <= 1'b0;
            sw_next_itr <= 1'b0;
            fill_kick   <= 1'b0;
            shift_kick  <= 1'b0;
        end else begin
            // kicks are single-cycle pulses
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            case (state)
                sc_idle: begin
                    fill_kick <= 1'b1;
                    state     <= sc_fill;
                end
                sc_fill: begin
                    if (fill_done) begin
                        sw_swap <= 1'b1;
                        state   <= sc_swap;
                    end
                end
                sc_swap: begin
                    // request held until acknowledged
                    if (sw_swap_ack) begin
                        sw_swap    <= 1'b0;
                        shift_kick <= 1'b1;
                        state      <= sc_shift;
                    end
                end
                sc_shift: begin
                    if (shift_done) begin
                        sw_next_itr <= 1'b1;
                        state       <= sc_next;
                    end
                end
                sc_next: begin
                    if (sw_next_itr_ack) begin
                        sw_next_itr <= 1'b0;
                        fill_kick   <= 1'b1;
                        state       <= sc_fill;
                    end
                end
                default: begin
                    state <= sc_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --top-module nabp_tb -f src.f -o nabp_sim

./obj_dir/nabp_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
echo "simulation did not pass"
exit 1

/* src.f */
rtl/nabp_pkg.sv
rtl/nabp_state_control.sv
rtl/nabp_shifter.sv
rtl/nabp_mapper.sv
rtl/nabp_line_buffer.sv
rtl/nabp_processing_swappable.sv
verification/nabp_assertions.sv
verification/nabp_checker.sv
verification/nabp_tb.sv

/* verification/nabp_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_assertions (
    input wire logic clk,
    input wire logic reset,
    input wire logic sw_swap,
    input wire logic sw_next_itr,
    input wire logic sw_swap_ack,
    input wire logic sw_next_itr_ack,
    input wire logic fill_kick,
    input wire logic shift_kick
);

    // kicks last one cycle
    fill_kick_pulse: assert property (@(posedge clk) disable iff (reset)
        fill_kick |=> !fill_kick) else $error("fill_kick longer than one cycle");

    shift_kick_pulse: assert property (@(posedge clk) disable iff (reset)
        shift_kick |=> !shift_kick) else $error("shift_kick longer than one cycle");

    swap_held: assert property (@(posedge clk) disable iff (reset)
        sw_swap && !sw_swap_ack |=> sw_swap) else $error("sw_swap dropped without ack");

    swap_released: assert property (@(posedge clk) disable iff (reset)
        sw_swap && sw_swap_ack |=> !sw_swap) else $error("sw_swap held after ack");

    next_held: assert property (@(posedge clk) disable iff (reset)
        sw_next_itr && !sw_next_itr_ack |=> sw_next_itr)
        else $error("sw_next_itr dropped without ack");

    next_released: assert property (@(posedge clk) disable iff (reset)
        sw_next_itr && sw_next_itr_ack |=> !sw_next_itr)
        else $error("sw_next_itr held after ack");

    // one request at a time
    requests_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(sw_swap && sw_next_itr)) else $error("both requests high");

endmodule

`default_nettype wire

/* verification/nabp_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_checker
    import nabp_pkg::*;
#(
    parameter int DATA_WIDTH     = 16,
    parameter int NUM_PARTITIONS = 4,
    parameter int PARTITION_SIZE = 8
) (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire swap_params_t                         sw_params,
    input  wire logic                                 sw_swap,
    input  wire logic                                 sw_swap_ack,
    input  wire logic                                 sw_next_itr,
    input  wire logic                                 sw_next_itr_ack,
    input  wire logic                                 sw_pe_en,
    input  wire logic [S_WIDTH-1:0]                   fr_s_val,
    input  wire logic [NUM_PARTITIONS*DATA_WIDTH-1:0] pe_taps,
    output int                                        errors,
    output int                                        iterations
);

    localparam int FILL_LEN = NUM_PARTITIONS * PARTITION_SIZE;

    typedef enum {w_fill, w_swap, w_shift, w_next} wait_t;

    wait_t                                mode;
    logic                                 started;
    int                                   cyc;
    int                                   pe_i;
    int                                   iter_errors;
    swap_params_t                         p;
    logic [S_WIDTH-1:0]                   held;
    logic                                 swap_prev;
    logic                                 swap_ack_prev;
    logic                                 next_prev;
    logic                                 next_ack_prev;
    logic [S_WIDTH-1:0]                   addr_prev;
    logic [NUM_PARTITIONS*DATA_WIDTH-1:0] taps_prev;

    function automatic logic [DATA_WIDTH-1:0] ram_word(input logic [S_WIDTH-1:0] a);
        return DATA_WIDTH'(32'(a) * 37 + 5);
    endfunction

    // integer part of init + k * base with wraparound at ACCU_WIDTH
    function automatic logic [S_WIDTH-1:0] addr_at(input int k);
        logic [ACCU_WIDTH-1:0] acc;
        acc = p.map_accu_init + ACCU_WIDTH'(k) * p.map_accu_base;
        return acc[ACCU_WIDTH-1:ACCU_FRAC];
    endfunction

    // whole samples the phase has stepped over before PE cycle upto
    function automatic int carries_before(input int upto);
        int cycles;
        cycles = upto;
        if (cycles < 0) cycles = 0;
        if (cycles > PARTITION_SIZE) cycles = PARTITION_SIZE;
        return (cycles * int'(p.shift_accu_base[ACCU_FRAC:0])) >> ACCU_FRAC;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("FAIL t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
        errors++;
        iter_errors++;
    endtask

    task automatic report_event(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
        iter_errors++;
    endtask

    task automatic expect_addr(input logic [S_WIDTH-1:0] exp);
        if (fr_s_val != exp) report_value("fr_s_val", 64'(fr_s_val), 64'(exp));
    endtask

    task automatic start_iteration();
        p           = sw_params;
        mode        = w_fill;
        cyc         = 0;
        iter_errors = 0;
    endtask

    // slot j of the model line buffer holds sample n - j * PARTITION_SIZE
    task automatic check_taps(input int n);
        logic [DATA_WIDTH-1:0] exp;
        for (int j = 0; j < NUM_PARTITIONS; j++) begin
            exp = ram_word(addr_at(n - j * PARTITION_SIZE));
            if (pe_taps[j*DATA_WIDTH +: DATA_WIDTH] != exp) begin
                report_value($sformatf("pe_taps[%0d]", j),
                             64'(pe_taps[j*DATA_WIDTH +: DATA_WIDTH]), 64'(exp));
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            started    = 1'b0;
            errors     = 0;
            iterations = 0;
            held       = '0;
            swap_prev  = 1'b0;
            next_prev  = 1'b0;
        end else begin
            // request levels hold until acknowledged and fall right after
            if (swap_prev && swap_ack_prev && sw_swap) report_value("sw_swap", 1, 0);
            if (swap_prev && !swap_ack_prev && !sw_swap) report_value("sw_swap", 0, 1);
            if (next_prev && next_ack_prev && sw_next_itr) report_value("sw_next_itr", 1, 0);
            if (next_prev && !next_ack_prev && !sw_next_itr) report_value("sw_next_itr", 0, 1);
            // nothing moves under back-pressure
            if ((swap_prev && sw_swap) || (next_prev && sw_next_itr)) begin
                if (fr_s_val != addr_prev) report_value("fr_s_val", 64'(fr_s_val), 64'(addr_prev));
                if (pe_taps != taps_prev) report_value("pe_taps", pe_taps, taps_prev);
            end
            if (sw_pe_en && mode != w_shift) report_value("sw_pe_en", 1, 0);

            if (!started) begin
                if (sw_swap || sw_next_itr) report_event("request high right after reset");
                expect_addr('0);
                start_iteration();
                started = 1'b1;
            end else begin
                cyc++;
                case (mode)
                    w_fill: begin
                        if (sw_next_itr) report_event("sw_next_itr raised during fill");
                        if (cyc < 3) begin
                            expect_addr(held);
                        end else if (cyc <= FILL_LEN + 3) begin
                            expect_addr(addr_at(cyc - 3));
                        end else begin
                            expect_addr(addr_at(FILL_LEN));
                        end
                        if (sw_swap) begin
                            if (cyc <= FILL_LEN + 3) report_event("sw_swap before fill ended");
                            mode = w_swap;
                        end
                    end
                    w_swap: begin
                        expect_addr(addr_at(FILL_LEN));
                        if (sw_swap && sw_swap_ack) begin
                            pe_i = 0;
                            mode = w_shift;
                        end
                    end
                    w_shift: begin
                        if (sw_swap) report_event("second sw_swap in one iteration");
                        if (sw_pe_en) begin
                            if (pe_i >= PARTITION_SIZE) begin
                                report_event("sw_pe_en longer than a partition");
                            end else begin
                                expect_addr(addr_at(FILL_LEN + carries_before(pe_i)));
                                check_taps(FILL_LEN + carries_before(pe_i - 2));
                            end
                            pe_i++;
                        end else if (pe_i > 0 && pe_i < PARTITION_SIZE) begin
                            report_event("sw_pe_en dropped inside the shift pass");
                            pe_i = PARTITION_SIZE;
                        end
                        if (sw_next_itr) begin
                            if (pe_i != PARTITION_SIZE) report_value("pe cycles", 64'(pe_i),
                                                                     64'(PARTITION_SIZE));
                            expect_addr(addr_at(FILL_LEN + carries_before(PARTITION_SIZE)));
                            mode = w_next;
                        end
                    end
                    default: begin
                        if (sw_swap) report_event("sw_swap before the next iteration");
                        if (sw_next_itr && sw_next_itr_ack) begin
                            $display("iteration %0d: %0d errors", iterations, iter_errors);
                            iterations++;
                            held = fr_s_val;
                            start_iteration();
                        end
                    end
                endcase
            end
            swap_prev     = sw_swap;
            swap_ack_prev = sw_swap_ack;
            next_prev     = sw_next_itr;
            next_ack_prev = sw_next_itr_ack;
            addr_prev     = fr_s_val;
            taps_prev     = pe_taps;
        end
    end

endmodule

`default_nettype wire

/* verification/nabp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_tb
    import nabp_pkg::*;
;

    localparam int DATA_WIDTH     = 16;
    localparam int NUM_PARTITIONS = 4;
    localparam int PARTITION_SIZE = 8;
    localparam int TABLE_ROWS     = 6;
    localparam int RANDOM_ROWS    = 4;
    localparam int NUM_ROWS       = TABLE_ROWS + RANDOM_ROWS;
    localparam int MAX_DELAY      = 40;
    // fill and shift passes plus both acknowledge delays and a margin
    localparam int ROW_CYCLES     = NUM_PARTITIONS * PARTITION_SIZE + PARTITION_SIZE
                                    + 2 * MAX_DELAY + 40;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * ROW_CYCLES + 20;

    // one iteration of stimulus
    // end_addr is the address expected at sw_next_itr
    typedef struct packed {
        logic [ACCU_WIDTH-1:0] shift_base;
        logic [ACCU_WIDTH-1:0] init;
        logic [ACCU_WIDTH-1:0] base;
        int                    swap_dly;
        int                    next_dly;
        int                    end_addr;
    } row_t;

    logic                                  clk;
    logic                                  reset;
    swap_params_t                          sw_params;
    logic                                  sw_swap_ack;
    logic                                  sw_next_itr_ack;
    logic [DATA_WIDTH-1:0]                 fr_val;
    logic                                  sw_swap;
    logic                                  sw_next_itr;
    logic                                  sw_pe_en;
    logic [S_WIDTH-1:0]                    fr_s_val;
    logic [NUM_PARTITIONS*DATA_WIDTH-1:0]  pe_taps;
    int                                    chk_errors;
    int                                    iterations;
    int                                    end_errors;
    row_t                                  rows [NUM_ROWS];

    nabp_processing_swappable #(
        .DATA_WIDTH     (DATA_WIDTH),
        .NUM_PARTITIONS (NUM_PARTITIONS),
        .PARTITION_SIZE (PARTITION_SIZE)
    ) UUT (
        .clk             (clk),
        .reset           (reset),
        .sw_params       (sw_params),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr_ack (sw_next_itr_ack),
        .fr_val          (fr_val),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .sw_pe_en        (sw_pe_en),
        .fr_s_val        (fr_s_val),
        .pe_taps         (pe_taps)
    );

    nabp_checker #(
        .DATA_WIDTH     (DATA_WIDTH),
        .NUM_PARTITIONS (NUM_PARTITIONS),
        .PARTITION_SIZE (PARTITION_SIZE)
    ) scoreboard (
        .clk             (clk),
        .reset           (reset),
        .sw_params       (sw_params),
        .sw_swap         (sw_swap),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr     (sw_next_itr),
        .sw_next_itr_ack (sw_next_itr_ack),
        .sw_pe_en        (sw_pe_en),
        .fr_s_val        (fr_s_val),
        .pe_taps         (pe_taps),
        .errors          (chk_errors),
        .iterations      (iterations)
    );

    bind nabp_state_control nabp_assertions request_checks (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // filtered RAM with one cycle of read latency
    always @(posedge clk) begin
        fr_val <= DATA_WIDTH'(32'(fr_s_val) * 37 + 5);
    end

    function automatic swap_params_t params_of(input row_t r);
        return '{shift_accu_base: r.shift_base, map_accu_init: r.init, map_accu_base: r.base};
    endfunction

    task automatic load_table();
        // shift step, init, address step, swap delay, next delay, end address
        rows[0] = '{18'h00100, 18'h00000, 18'h00100, 0, 0, 32'h028};
        rows[1] = '{18'h00080, 18'h00a80, 18'h00080, 2, 5, 32'h01c};
        rows[2] = '{18'h00040, 18'h03040, 18'h00200, 25, 3, 32'h074};
        rows[3] = '{18'h000c0, 18'h10000, 18'h00180, 0, 30, 32'h139};
        // address wraps past the top of the RAM
        rows[4] = '{18'h00000, 18'h3ff00, 18'h00100, 40, 40, 32'h01f};
        rows[5] = '{18'h00100, 18'h00123, 18'h00055, 1, 1, 32'h00e};
        for (int i = TABLE_ROWS; i < NUM_ROWS; i++) begin
            rows[i].shift_base = ACCU_WIDTH'($urandom % 257);
            rows[i].init       = ACCU_WIDTH'($urandom);
            rows[i].base       = ACCU_WIDTH'($urandom % 1024);
            rows[i].swap_dly   = int'($urandom % 20);
            rows[i].next_dly   = int'($urandom % 20);
            rows[i].end_addr   = -1;
        end
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("timeout: the DUT stopped making progress through the iterations");
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(87317));
        reset           = 1'b1;
        sw_swap_ack     = 1'b0;
        sw_next_itr_ack = 1'b0;
        fr_val          = '0;
        end_errors      = 0;
        load_table();
        sw_params = params_of(rows[0]);
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            do @(posedge clk); while (!sw_swap);
            repeat (rows[r].swap_dly) @(posedge clk);
            sw_swap_ack <= 1'b1;
            // next settings only take effect at the next fill start
            if (r + 1 < NUM_ROWS) begin
                sw_params <= params_of(rows[r+1]);
            end
            @(posedge clk);
            sw_swap_ack <= 1'b0;
            do @(posedge clk); while (!sw_next_itr);
            if (rows[r].end_addr >= 0 && 32'(fr_s_val) != rows[r].end_addr) begin
                $display("FAIL t=%0t fr_s_val: got 0x%0h expected 0x%0h",
                         $time, fr_s_val, rows[r].end_addr);
                end_errors++;
            end
            repeat (rows[r].next_dly) @(posedge clk);
            sw_next_itr_ack <= 1'b1;
            @(posedge clk);
            sw_next_itr_ack <= 1'b0;
        end

        repeat (4) @(posedge clk);
        $display("summary: %0d of %0d iterations, %0d checker errors, %0d end address errors",
                 iterations, NUM_ROWS, chk_errors, end_errors);
        if (chk_errors == 0 && end_errors == 0 && iterations == NUM_ROWS) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
